/* hdl/uvc_pkg.sv */
//----------------------------------------------------------------------
// uvc stream package
// frame formats, payload header constants and the size arithmetic
// shared by the packetizers and the probe/commit responder
//----------------------------------------------------------------------
`default_nettype none

package uvc_pkg;

    typedef enum logic {
        FRAME_MONO = 1'b0,                              // gray, U/V filled with neutral
        FRAME_YUY2 = 1'b1                               // every byte fetched from user
    } frame_type_e;

    localparam logic [7:0]  HDR_LEN     = 8'd2;         // header length, also header byte 0
    localparam logic [7:0]  BFH_BASE    = 8'h80;        // EOH set, eof in bit 1, fid in bit 0
    localparam logic [7:0]  MONO_CHROMA = 8'h80;        // neutral U and V
    localparam int unsigned PROBE_LEN   = 34;
    localparam logic [31:0] CLOCK_FREQ  = 32'd6_000_000; // dwClockFrequency

    // two bytes per pixel for both formats
    function automatic logic [31:0] frame_bytes(input logic [13:0] w, input logic [13:0] h);
        return 32'(w) * 32'(h) * 32'd2;
    endfunction

    function automatic logic [31:0] packet_count(input logic [31:0] fbytes,
                                                 input logic [9:0]  psize);
        logic [31:0] pay;
        pay = 32'(psize) - 32'(HDR_LEN);                // payload bytes per packet
        return (fbytes + pay - 32'd1) / pay;            // round up
    endfunction

    function automatic logic [31:0] last_packet_size(input logic [31:0] fbytes,
                                                     input logic [9:0]  psize);
        logic [31:0] pay;
        logic [31:0] rem;
        pay = 32'(psize) - 32'(HDR_LEN);
        rem = fbytes % pay;
        return ((rem == 32'd0) ? pay : rem) + 32'(HDR_LEN); // header included
    endfunction

    // one byte of the probe/commit control block, little endian fields
    function automatic logic [7:0] probe_commit_byte(input logic [8:0]  idx,
                                                     input logic [31:0] fbytes,
                                                     input logic [9:0]  psize);
        logic [31:0] intv;
        logic [31:0] maxpay;
        intv   = packet_count(fbytes, psize) * 32'd10000; // one packet per ms, in 100 ns units
        maxpay = 32'(psize);
        case (idx)
            9'd2, 9'd3:                return 8'h01;     // format and frame index
            9'd4, 9'd5, 9'd6, 9'd7:    return intv[8*(idx-9'd4) +: 8];
            9'd16:                     return 8'h01;     // wDelay = 1 ms
            9'd18, 9'd19, 9'd20, 9'd21: return fbytes[8*(idx-9'd18) +: 8];
            9'd22, 9'd23, 9'd24, 9'd25: return maxpay[8*(idx-9'd22) +: 8];
            9'd26, 9'd27, 9'd28, 9'd29: return CLOCK_FREQ[8*(idx-9'd26) +: 8];
            9'd30:                     return 8'h03;     // bmFramingInfo, fid and eof used
            default:                   return 8'h00;     // hints, rates, versions, past end
        endcase
    endfunction

endpackage

`default_nettype wire

/* hdl/usb_frame_sched.sv */
//----------------------------------------------------------------------
// usb frame scheduler
// starts each stream's packet in turn after a usb start-of-frame
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module usb_frame_sched #(
    parameter int NUM_STREAMS = 2
) (
    input  logic                   clk,
    input  logic                   usb_rstn,
    input  logic                   sof,                 // usb start-of-frame pulse
    input  logic [NUM_STREAMS-1:0] done,                // packet finished, per stream
    output logic [NUM_STREAMS-1:0] start                // packet start pulse, per stream
);

    localparam int               IDX_W    = (NUM_STREAMS > 1) ? $clog2(NUM_STREAMS) : 1;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_STREAMS - 1);

    logic             busy;                             // round in progress
    logic [IDX_W-1:0] idx;                              // stream currently sending

    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            busy  <= 1'b0;
            idx   <= '0;
            start <= '0;
        end else begin
            start <= '0;                                // pulses only
            if (!busy) begin
                if (sof) begin                          // new usb frame, stream 0 first
                    busy     <= 1'b1;
                    idx      <= '0;
                    start[0] <= 1'b1;
                end
            end else if (done[idx]) begin
                if (idx == LAST_IDX) begin
                    busy <= 1'b0;                       // round over, wait for next sof
                end else begin
                    idx               <= idx + 1'b1;
                    start[idx + 1'b1] <= 1'b1;          // hand over to next stream
                end
            end
            // sof during busy is dropped
        end
    end

endmodule

`default_nettype wire

/* hdl/uvc_packetizer.sv */
//----------------------------------------------------------------------
// uvc packetizer
// builds one payload packet per start: header length, framing byte,
// then pixel bytes fetched from the user with vf_sof / vf_req
// mono streams get neutral chroma in the U and V slots
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module uvc_packetizer #(
    parameter logic [13:0]          FRAME_W     = 14'd320,
    parameter logic [13:0]          FRAME_H     = 14'd240,
    parameter logic [9:0]           PACKET_SIZE = 10'd802,
    parameter uvc_pkg::frame_type_e FRAME_TYPE  = uvc_pkg::FRAME_YUY2
) (
    input  logic       clk,
    input  logic       usb_rstn,
    input  logic       start,                           // from scheduler
    input  logic       byte_take,                       // byte_data taken by merger
    output logic [7:0] byte_data,
    output logic       byte_valid,
    output logic       done,                            // pulse after last byte taken
    output logic       vf_sof,                          // start of video frame to user
    output logic       vf_req,                          // vf_byte sampled this cycle
    input  logic [7:0] vf_byte
);

    localparam logic [31:0] FBYTES    = uvc_pkg::frame_bytes(FRAME_W, FRAME_H);
    localparam logic [31:0] NPKT      = uvc_pkg::packet_count(FBYTES, PACKET_SIZE);
    localparam logic [31:0] LAST_SIZE = uvc_pkg::last_packet_size(FBYTES, PACKET_SIZE);
    localparam logic        IS_YUY2   = (FRAME_TYPE == uvc_pkg::FRAME_YUY2);

    logic [9:0]  bcnt;                                  // index of byte on byte_data
    logic [9:0]  bnext;
    logic [31:0] pcnt;                                  // packet within video frame
    logic        fid;
    logic        plast;                                 // last packet of the frame
    logic [9:0]  psize;                                 // size incl header
    logic        fetch;                                 // next payload byte from user
    logic        take;

    assign take  = byte_valid && byte_take;
    assign bnext = bcnt + 10'd1;
    assign plast = (pcnt == NPKT - 32'd1);
    assign psize = plast ? LAST_SIZE[9:0] : PACKET_SIZE;
    assign fetch = IS_YUY2 || !bnext[0];                // even payload offset of mono is Y

    //------------------------------------------------------------------
    // control
    //------------------------------------------------------------------
    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            byte_valid <= 1'b0;
            bcnt       <= '0;
            pcnt       <= '0;
            fid        <= 1'b0;
            done       <= 1'b0;
            vf_sof     <= 1'b0;
            vf_req     <= 1'b0;
        end else begin
            done   <= 1'b0;
            vf_sof <= 1'b0;
            vf_req <= 1'b0;
            if (start) begin
                byte_valid <= 1'b1;                     // header length goes out first
                bcnt       <= '0;
            end else if (vf_req) begin
                byte_valid <= 1'b1;                     // fetched byte now on byte_data
            end else if (take) begin
                bcnt   <= bnext;
                vf_sof <= (bcnt == 10'd0) && (pcnt == 32'd0);
                if (bnext == psize) begin               // packet complete
                    byte_valid <= 1'b0;
                    done       <= 1'b1;
                    if (plast) begin
                        pcnt <= '0;
                        fid  <= ~fid;                   // next video frame
                    end else begin
                        pcnt <= pcnt + 32'd1;
                    end
                end else if (bnext >= 10'd2 && fetch) begin
                    byte_valid <= 1'b0;                 // gap while user supplies byte
                    vf_req     <= 1'b1;
                end
            end
        end
    end

    //------------------------------------------------------------------
    // byte register
    //------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (start) begin
            byte_data <= uvc_pkg::HDR_LEN;
        end else if (vf_req) begin
            byte_data <= vf_byte;                       // captured at the vf_req edge
        end else if (take) begin
            if (bnext == 10'd1) begin
                byte_data <= uvc_pkg::BFH_BASE | {6'd0, plast, fid};
            end else if (!fetch) begin
                byte_data <= uvc_pkg::MONO_CHROMA;      // U or V slot of mono
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/ep_tx_mux.sv */
//----------------------------------------------------------------------
// transmit merger
// one-deep output register that drains the single active packetizer
// into a tagged byte stream for the iso IN endpoint
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module ep_tx_mux #(
    parameter  int NUM_STREAMS = 2,
    localparam int IDX_W       = (NUM_STREAMS > 1) ? $clog2(NUM_STREAMS) : 1
) (
    input  logic                        clk,
    input  logic                        usb_rstn,
    input  logic [NUM_STREAMS-1:0][7:0] byte_data,
    input  logic [NUM_STREAMS-1:0]      byte_valid,
    output logic [NUM_STREAMS-1:0]      byte_take,      // byte loaded this cycle
    output logic [7:0]                  tx_data,
    output logic                        tx_valid,
    output logic [IDX_W-1:0]            tx_ep,          // stream index of tx_data
    input  logic                        tx_ready
);

    logic [IDX_W-1:0] sel;                              // active requester
    logic             load;

    // at most one requester is valid at a time
    always_comb begin
        sel = '0;
        for (int i = 0; i < NUM_STREAMS; i++) begin
            if (byte_valid[i]) begin
                sel = IDX_W'(i);
            end
        end
    end

    assign load = (|byte_valid) && (!tx_valid || tx_ready); // empty or draining

    always_comb begin
        byte_take      = '0;
        byte_take[sel] = load;
    end

    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            tx_valid <= 1'b0;
        end else if (load) begin
            tx_valid <= 1'b1;
        end else if (tx_ready) begin
            tx_valid <= 1'b0;                           // drained, nothing new
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin                                 // held under back-pressure
            tx_data <= byte_data[sel];
            tx_ep   <= sel;
        end
    end

endmodule

`default_nettype wire

/* hdl/uvc_probe_commit.sv */
//----------------------------------------------------------------------
// probe/commit responder
// answers the class GET request on endpoint 0 with the 34 byte
// video probe/commit control block, one byte per resp_idx
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module uvc_probe_commit #(
    parameter logic [13:0] FRAME_W     = 14'd320,
    parameter logic [13:0] FRAME_H     = 14'd240,
    parameter logic [9:0]  PACKET_SIZE = 10'd802
) (
    input  logic        clk,
    input  logic [63:0] setup_cmd,                      // 8 byte setup packet
    input  logic [8:0]  resp_idx,                       // byte index requested by core
    output logic [7:0]  resp
);

    localparam logic [31:0] FBYTES = uvc_pkg::frame_bytes(FRAME_W, FRAME_H);

    logic match;

    // class request to interface, VS_PROBE_CONTROL selector, interface 1
    assign match = (setup_cmd[7:0]   == 8'hA1)
                && (setup_cmd[31:16] == 16'h0100)       // wValue, selector in high byte
                && (setup_cmd[47:32] == 16'h0001);      // wIndex

    always_ff @(posedge clk) begin
        if (match && (resp_idx < uvc_pkg::PROBE_LEN)) begin
            resp <= uvc_pkg::probe_commit_byte(resp_idx, FBYTES, PACKET_SIZE);
        end else begin
            resp <= 8'h00;
        end
    end

endmodule

`default_nettype wire

/* hdl/uvc_stream_top.sv */
//----------------------------------------------------------------------
// uvc streaming top
// scheduler, one packetizer per camera stream, the transmit merger
// and the probe/commit responder
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module uvc_stream_top #(
    parameter  int                                     NUM_STREAMS = 2,
    parameter  logic [13:0]                            FRAME_W     = 14'd320, // even
    parameter  logic [13:0]                            FRAME_H     = 14'd240, // even
    parameter  logic [9:0]                             PACKET_SIZE = 10'd802, // header + payload
    parameter  uvc_pkg::frame_type_e [NUM_STREAMS-1:0] FRAME_TYPES =
        {uvc_pkg::FRAME_MONO, uvc_pkg::FRAME_YUY2},
    localparam int                                     IDX_W       =
        (NUM_STREAMS > 1) ? $clog2(NUM_STREAMS) : 1
) (
    input  logic                        clk,
    input  logic                        usb_rstn,
    input  logic                        sof,            // usb start-of-frame
    input  logic                        tx_ready,       // iso IN endpoint accept
    input  logic [63:0]                 setup_cmd,
    input  logic [8:0]                  resp_idx,
    input  logic [NUM_STREAMS-1:0][7:0] vf_byte,
    output logic [NUM_STREAMS-1:0]      vf_sof,
    output logic [NUM_STREAMS-1:0]      vf_req,
    output logic [7:0]                  tx_data,
    output logic                        tx_valid,
    output logic [IDX_W-1:0]            tx_ep,
    output logic [7:0]                  resp
);

    logic [NUM_STREAMS-1:0]      start;
    logic [NUM_STREAMS-1:0]      done;
    logic [NUM_STREAMS-1:0][7:0] byte_data;
    logic [NUM_STREAMS-1:0]      byte_valid;
    logic [NUM_STREAMS-1:0]      byte_take;

    usb_frame_sched #(
        .NUM_STREAMS (NUM_STREAMS)
    ) i_usb_frame_sched (
        .clk      (clk),
        .usb_rstn (usb_rstn),
        .sof      (sof),
        .done     (done),
        .start    (start)
    );

    for (genvar i = 0; i < NUM_STREAMS; i++) begin : g_stream
        uvc_packetizer #(
            .FRAME_W     (FRAME_W),
            .FRAME_H     (FRAME_H),
            .PACKET_SIZE (PACKET_SIZE),
            .FRAME_TYPE  (FRAME_TYPES[i])
        ) i_uvc_packetizer (
            .clk        (clk),
            .usb_rstn   (usb_rstn),
            .start      (start[i]),
            .byte_take  (byte_take[i]),
            .byte_data  (byte_data[i]),
            .byte_valid (byte_valid[i]),
            .done       (done[i]),
            .vf_sof     (vf_sof[i]),
            .vf_req     (vf_req[i]),
            .vf_byte    (vf_byte[i])
        );
    end

    ep_tx_mux #(
        .NUM_STREAMS (NUM_STREAMS)
    ) i_ep_tx_mux (
        .clk        (clk),
        .usb_rstn   (usb_rstn),
        .byte_data  (byte_data),
        .byte_valid (byte_valid),
        .byte_take  (byte_take),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_ep      (tx_ep),
        .tx_ready   (tx_ready)
    );

    uvc_probe_commit #(
        .FRAME_W     (FRAME_W),
        .FRAME_H     (FRAME_H),
        .PACKET_SIZE (PACKET_SIZE)
    ) i_uvc_probe_commit (
        .clk       (clk),
        .setup_cmd (setup_cmd),
        .resp_idx  (resp_idx),
        .resp      (resp)
    );

endmodule

`default_nettype wire

/* tb/tb_clkgen.sv */
//----------------------------------------------------------------------
// testbench clock and reset
// 40 ns clock, usb_rstn held low for the first three rising edges
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen #(
    parameter int HALF_PERIOD = 20,                     // ns
    parameter int RST_CYCLES  = 3
) (
    output logic clk,
    output logic usb_rstn
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        usb_rstn = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        usb_rstn <= 1'b1;                               // release on a rising edge
    end

endmodule

`default_nettype wire

/* tb/uvc_stream_tb.sv */
//----------------------------------------------------------------------
// uvc streaming testbench
// directed tests of packet order, headers, payload, packet sizes,
// iso IN back-pressure and the probe/commit responder
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module uvc_stream_tb;

    localparam int NS      = 2;
    localparam int PS      = 12;                        // header + payload
    localparam int FBYTES  = 4 * 2 * 2;                 // 4x2 pixels, two bytes each
    localparam int PAYLOAD = PS - 2;
    localparam int PKTS    = (FBYTES + PAYLOAD - 1) / PAYLOAD;
    localparam int LAST    = FBYTES - (PKTS - 1) * PAYLOAD + 2;
    localparam int TIMEOUT = 12 * (8 * NS * PS + 16) + 2 * 3 * 36 + 500; // rounds, probe, margin
    localparam logic [NS-1:0] IS_MONO = 2'b10;          // stream 0 yuy2, stream 1 mono

    logic               clk;
    logic               usb_rstn;
    logic               sof       = 1'b0;
    logic               tx_ready  = 1'b1;
    logic [63:0]        setup_cmd = '0;
    logic [8:0]         resp_idx  = '0;
    logic [NS-1:0][7:0] vf_byte   = '0;
    logic [NS-1:0]      vf_sof;
    logic [NS-1:0]      vf_req;
    logic [7:0]         tx_data;
    logic               tx_valid;
    logic               tx_ep;
    logic [7:0]         resp;

    logic [255:0] ready_bits;                           // random tx_ready pattern
    logic         bp_on    = 1'b0;
    logic         held     = 1'b0;                      // byte held off last cycle
    logic [7:0]   held_data;
    logic         held_ep;
    int           cycles   = 0;
    int           round_no = 0;                         // sof rounds since reset
    int           req_pulses [NS] = '{default: 0};
    int           sof_pulses [NS] = '{default: 0};
    logic [7:0]   rx_data [$];                          // bytes taken by the core
    logic         rx_ep [$];

    tb_clkgen i_tb_clkgen (.*);

    uvc_stream_top #(
        .NUM_STREAMS (NS),
        .FRAME_W     (14'd4),
        .FRAME_H     (14'd2),
        .PACKET_SIZE (10'(PS)),
        .FRAME_TYPES ({uvc_pkg::FRAME_MONO, uvc_pkg::FRAME_YUY2})
    ) i_uvc_stream_top (.*);

    function automatic logic [7:0] pixel(input int s, input int n);
        return 8'(8'h11 * (s + 1) + n);                 // per-stream ramp
    endfunction

    // k-th byte of packet p, frame-id fid, for stream s
    function automatic logic [7:0] expected_byte(input int s, input int p, input int fid,
                                                 input int k);
        int off;
        off = p * PAYLOAD + k - 2;                      // offset in video frame
        if (k == 0) return uvc_pkg::HDR_LEN;
        if (k == 1) return uvc_pkg::BFH_BASE | 8'((p == PKTS - 1) * 2 + fid);
        if (!IS_MONO[s]) return pixel(s, off);
        return off[0] ? uvc_pkg::MONO_CHROMA : pixel(s, off / 2);
    endfunction

    // probe/commit block, little endian fields
    function automatic logic [7:0] probe_expected(input int idx);
        logic [7:0] blk [34];
        blk = '{default: 8'h00};
        blk[2]  = 8'h01;                                // format index
        blk[3]  = 8'h01;                                // frame index
        {blk[7], blk[6], blk[5], blk[4]}     = 32'(PKTS * 10000); // interval, 100 ns
        blk[16] = 8'h01;                                // delay in ms
        {blk[21], blk[20], blk[19], blk[18]} = 32'(FBYTES);
        {blk[25], blk[24], blk[23], blk[22]} = 32'(PS);
        {blk[29], blk[28], blk[27], blk[26]} = 32'd6_000_000; // clock frequency
        blk[30] = 8'h03;                                // fid and eof in use
        return (idx < 34) ? blk[idx] : 8'h00;
    endfunction

    task automatic abort_run(input string why);
        $display("TEST FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("error: %s is 0x%0h, expected 0x%0h", name, got, exp);
        abort_run("a value did not match, see the error line above");
    endtask

    // user pixel source, ramp restarts at each vf_sof
    always @(posedge clk) begin
        for (int s = 0; s < NS; s++) begin
            if (vf_sof[s]) begin
                vf_byte[s]    <= pixel(s, 0);
                sof_pulses[s] <= sof_pulses[s] + 1;
            end else if (vf_req[s]) begin               // byte sampled at this edge
                vf_byte[s]    <= vf_byte[s] + 8'd1;
                req_pulses[s] <= req_pulses[s] + 1;
            end
        end
    end

    // cycle counter, tx_ready drive and run limit
    always @(posedge clk) begin
        cycles   <= cycles + 1;
        tx_ready <= bp_on ? ready_bits[cycles[7:0]] : 1'b1;
        if (cycles == TIMEOUT) begin
            abort_run("timeout, the tests did not finish in time");
        end
    end

    // iso IN side monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (held) begin                                 // stalled byte must stay put
            assert (tx_valid) else abort_run("tx_valid dropped while tx_ready was low");
            assert (tx_data == held_data) else report_mismatch("tx_data", tx_data, held_data);
            assert (tx_ep == held_ep) else report_mismatch("tx_ep", tx_ep, held_ep);
        end
        held      = tx_valid && !tx_ready;
        held_data = tx_data;
        held_ep   = tx_ep;
        if (tx_valid && tx_ready) begin                 // transfer at next rising edge
            rx_data.push_back(tx_data);
            rx_ep.push_back(tx_ep);
        end
    end

    // one sof round: each stream sends one packet of sz bytes
    task automatic run_round(input bit check_pay, input int sz);
        int         p;
        int         fid;
        int         s;
        int         k;
        int         n [NS];
        int         req0 [NS];
        int         sof0 [NS];
        logic [7:0] exp;
        p    = round_no % PKTS;
        fid  = (round_no / PKTS) % 2;                   // toggles per video frame
        n    = '{default: 0};
        req0 = req_pulses;
        sof0 = sof_pulses;
        @(posedge clk);
        sof <= 1'b1;
        @(posedge clk);
        sof <= 1'b0;
        while (rx_data.size() < NS * sz) @(posedge clk);
        repeat (6) @(posedge clk);                      // quiet gap shows extra bytes
        foreach (rx_ep[i]) n[rx_ep[i]]++;
        for (int j = 0; j < NS; j++) begin
            s = IS_MONO[j] ? (sz - 2) / 2 : sz - 2;     // bytes fetched from user
            assert (n[j] == sz) else report_mismatch("packet size", n[j], sz);
            assert (req_pulses[j] - req0[j] == s)
                else report_mismatch("vf_req pulses", req_pulses[j] - req0[j], s);
            assert (sof_pulses[j] - sof0[j] == (p == 0))
                else report_mismatch("vf_sof pulses", sof_pulses[j] - sof0[j], p == 0);
        end
        for (int i = 0; i < NS * sz; i++) begin
            s   = i / sz;
            k   = i % sz;
            exp = expected_byte(s, p, fid, k);
            assert (rx_ep[i] == 1'(s)) else report_mismatch("tx_ep", rx_ep[i], s);
            if (check_pay || k < 2) begin
                assert (rx_data[i] == exp) else report_mismatch("tx_data", rx_data[i], exp);
            end
        end
        rx_data.delete();
        rx_ep.delete();
        round_no++;
    endtask

    task automatic test_reset();
        while (!usb_rstn) @(posedge clk);
        repeat (10) begin                               // no sof yet
            @(negedge clk);
            assert (!tx_valid) else report_mismatch("tx_valid", tx_valid, 0);
            assert (vf_sof == '0) else report_mismatch("vf_sof", vf_sof, 0);
            assert (vf_req == '0) else report_mismatch("vf_req", vf_req, 0);
        end
    endtask

    task automatic test_order_header();
        run_round(1'b0, PS);                            // packet 0, eof clear
        run_round(1'b0, LAST);                          // packet 1, eof set
    endtask

    task automatic test_payload();
        run_round(1'b1, PS);
        run_round(1'b1, LAST);
    endtask

    task automatic test_packet_sizes();
        int sizes [4] = '{12, 8, 12, 8};                // two video frames
        foreach (sizes[i]) run_round(1'b1, sizes[i]);
    endtask

    task automatic test_backpressure();
        @(negedge clk);
        bp_on = 1'b1;
        repeat (2) begin
            run_round(1'b1, PS);
            run_round(1'b1, LAST);
        end
        @(negedge clk);
        bp_on = 1'b0;
    endtask

    task automatic test_probe_commit();
        logic [7:0] exp;
        for (int m = 0; m < 2; m++) begin               // matching, then wrong type
            @(posedge clk);
            setup_cmd <= {16'd34, 16'h0001, 16'h0100, 8'h81, (m == 0) ? 8'hA1 : 8'h21};
            for (int i = 0; i < 36; i++) begin          // two past the block end
                @(posedge clk);
                resp_idx <= 9'(i);
                @(posedge clk);
                @(negedge clk);
                exp = (m == 0) ? probe_expected(i) : 8'h00;
                assert (resp == exp) else report_mismatch("resp", resp, exp);
            end
        end
    endtask

    initial begin
        void'($urandom(32'h95d0));
        for (int i = 0; i < 8; i++) begin
            ready_bits[32*i +: 32] = $urandom;
        end
        test_reset();
        test_order_header();
        test_payload();
        test_packet_sizes();
        test_backpressure();
        test_probe_commit();
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
hdl/uvc_pkg.sv
hdl/usb_frame_sched.sv
hdl/uvc_packetizer.sv
hdl/ep_tx_mux.sv
hdl/uvc_probe_commit.sv
hdl/uvc_stream_top.sv
tb/tb_clkgen.sv
tb/uvc_stream_tb.sv

/* Bender.yml */
package:
  name: uvc_stream

sources:
  - hdl/uvc_pkg.sv
  - hdl/usb_frame_sched.sv
  - hdl/uvc_packetizer.sv
  - hdl/ep_tx_mux.sv
  - hdl/uvc_probe_commit.sv
  - hdl/uvc_stream_top.sv
  - target: test
    files:
      - tb/tb_clkgen.sv
      - tb/uvc_stream_tb.sv
